//--- logic/encoder_soc_params.svh
`ifndef ENCODER_SOC_PARAMS_SVH
`define ENCODER_SOC_PARAMS_SVH

// Wishbone word address
// The top bit picks the slave, the rest the register
`define WB_ADDR_W 4

// Encoder positions, count wraps between 23 and 0
`define ENC_POSITIONS 24

// Depth of the pin synchronizers
`define SYNC_STAGES 2

// Seven-segment digits on the board
`define NUM_DIGITS 8

`endif

//--- logic/encoder_soc_pkg.sv
`include "encoder_soc_params.svh"

package encoder_soc_pkg;

  // One digit, segment a in bit 0 up to g in bit 6, low lights it
  typedef logic [6:0] seg_t;

  // Display word, seen by the bus as one word and by the decoders as nibbles
  typedef union packed {
    logic [`NUM_DIGITS*4-1:0]    raw;
    logic [`NUM_DIGITS-1:0][3:0] digit;
  } disp_word_u;

  // Encoder register map
  typedef enum logic [`WB_ADDR_W-2:0] {
    ENC_POSITION = 3'd0,
    ENC_COLOR    = 3'd1,
    ENC_STATUS   = 3'd2,
    ENC_ENABLE   = 3'd3
  } enc_reg_e;

  // Display register map
  typedef enum logic [`WB_ADDR_W-2:0] {
    DISP_VALUE = 3'd0,
    DISP_BLANK = 3'd1
  } disp_reg_e;

endpackage

//--- logic/hexdisp.sv
`timescale 1ns/1ns

module hexdisp (
  input  logic [3:0]           in,
  output encoder_soc_pkg::seg_t out
);

  // Segment order g f e d c b a, active low
  always_comb begin
    case (in)
      4'h0: out = 7'b1000000;
      4'h1: out = 7'b1111001;
      4'h2: out = 7'b0100100;
      4'h3: out = 7'b0110000;
      4'h4: out = 7'b0011001;
      4'h5: out = 7'b0010010;
      4'h6: out = 7'b0000010;
      4'h7: out = 7'b1111000;
      4'h8: out = 7'b0000000;
      4'h9: out = 7'b0010000;
      // Letters, lower case b and d so they differ from 8 and 0
      4'ha: out = 7'b0001000;
      4'hb: out = 7'b0000011;
      4'hc: out = 7'b1000110;
      4'hd: out = 7'b0100001;
      4'he: out = 7'b0000110;
      default: out = 7'b0001110;
    endcase
  end

endmodule

//--- logic/quad_encoder_wb.sv
`timescale 1ns/1ns
`include "encoder_soc_params.svh"

module quad_encoder_wb (
  input  logic                  clock_50,
  input  logic                  reset,
  input  logic [1:0]            quad,
  input  logic                  button,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`WB_ADDR_W-2:0] adr,
  input  logic [31:0]           dat_w,
  output logic [31:0]           dat_r,
  output logic                  ack,
  output logic [2:0]            rgb
);

  import encoder_soc_pkg::*;

  localparam int POS_W = $clog2(`ENC_POSITIONS);

  logic [`SYNC_STAGES-1:0] a_sync;
  logic [`SYNC_STAGES-1:0] b_sync;
  logic [`SYNC_STAGES-1:0] btn_sync;
  logic                    a_level;
  logic                    b_level;
  logic                    btn_level;
  logic                    a_prev;
  logic                    btn_prev;
  logic                    a_rise;
  logic                    btn_rise;
  logic [POS_W-1:0]        position;
  logic [2:0]              color;
  logic                    enable;
  logic                    press_latch;
  logic                    held;
  logic                    access;
  logic                    wr_pos;
  logic                    wr_status;
  logic                    wr_enable;

  // Encoder pins and button are asynchronous to clock_50
  always_ff @(posedge clock_50) begin
    if (reset) begin
      a_sync   <= '0;
      b_sync   <= '0;
      btn_sync <= '0;
      a_prev   <= 1'b0;
      btn_prev <= 1'b0;
    end else begin
      a_sync   <= {a_sync[`SYNC_STAGES-2:0], quad[0]};
      b_sync   <= {b_sync[`SYNC_STAGES-2:0], quad[1]};
      btn_sync <= {btn_sync[`SYNC_STAGES-2:0], button};
      a_prev   <= a_level;
      btn_prev <= btn_level;
    end
  end

  assign a_level   = a_sync[`SYNC_STAGES-1];
  assign b_level   = b_sync[`SYNC_STAGES-1];
  assign btn_level = btn_sync[`SYNC_STAGES-1];
  assign a_rise    = a_level & ~a_prev;
  assign btn_rise  = btn_level & ~btn_prev;

  // One access per strobe, decoded in the cycle before ack
  assign access    = cyc && stb && !ack && !held;
  assign wr_pos    = access && we && (enc_reg_e'(adr) == ENC_POSITION);
  assign wr_status = access && we && (enc_reg_e'(adr) == ENC_STATUS);
  assign wr_enable = access && we && (enc_reg_e'(adr) == ENC_ENABLE);

  // Bus write beats a quadrature step in the same cycle
  always_ff @(posedge clock_50) begin
    if (reset) begin
      position <= '0;
    end else if (wr_pos) begin
      position <= POS_W'(dat_w % `ENC_POSITIONS);
    end else if (a_rise) begin
      if (!b_level) begin
        position <= (position == POS_W'(`ENC_POSITIONS - 1)) ? '0 : position + 1'b1;
      end else begin
        position <= (position == '0) ? POS_W'(`ENC_POSITIONS - 1) : position - 1'b1;
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (reset) begin
      press_latch <= 1'b0;
      enable      <= 1'b0;
    end else begin
      // A new press wins over a clearing write
      if (btn_rise) begin
        press_latch <= 1'b1;
      end else if (wr_status) begin
        press_latch <= 1'b0;
      end
      if (wr_enable) begin
        enable <= dat_w[0];
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (reset) begin
      ack  <= 1'b0;
      held <= 1'b0;
    end else begin
      ack <= access;
      if (!stb) begin
        held <= 1'b0;
      end else if (ack) begin
        held <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (access) begin
      case (enc_reg_e'(adr))
        ENC_POSITION: dat_r <= 32'(position);
        ENC_COLOR:    dat_r <= 32'(color);
        ENC_STATUS:   dat_r <= {30'b0, press_latch, btn_level};
        ENC_ENABLE:   dat_r <= {31'b0, enable};
        default:      dat_r <= '0;
      endcase
    end
  end

  // Red, green, blue for each third of a turn
  always_comb begin
    if (position < POS_W'(8)) begin
      color = 3'b100;
    end else if (position < POS_W'(16)) begin
      color = 3'b010;
    end else begin
      color = 3'b001;
    end
  end

  assign rgb = enable ? color : 3'b000;

  position_in_range: assert property (
    @(posedge clock_50) disable iff (reset) position < `ENC_POSITIONS
  );

  ack_needs_request: assert property (
    @(posedge clock_50) disable iff (reset) ack |-> (cyc && stb)
  );

endmodule

//--- logic/hex_display_wb.sv
`timescale 1ns/1ns
`include "encoder_soc_params.svh"

module hex_display_wb (
  input  logic                  clock_50,
  input  logic                  reset,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`WB_ADDR_W-2:0] adr,
  input  logic [31:0]           dat_w,
  output logic [31:0]           dat_r,
  output logic                  ack,
  output encoder_soc_pkg::seg_t hex [`NUM_DIGITS]
);

  import encoder_soc_pkg::*;

  disp_word_u             value;
  logic [`NUM_DIGITS-1:0] blank;
  logic                   held;
  logic                   access;
  seg_t                   decoded [`NUM_DIGITS];

  assign access = cyc && stb && !ack && !held;

  always_ff @(posedge clock_50) begin
    if (reset) begin
      value.raw <= '0;
      blank     <= '0;
      ack       <= 1'b0;
      held      <= 1'b0;
    end else begin
      ack <= access;
      if (!stb) begin
        held <= 1'b0;
      end else if (ack) begin
        held <= 1'b1;
      end
      if (access && we) begin
        case (disp_reg_e'(adr))
          DISP_VALUE: value.raw <= dat_w;
          DISP_BLANK: blank <= dat_w[`NUM_DIGITS-1:0];
          default:    ;
        endcase
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (access) begin
      case (disp_reg_e'(adr))
        DISP_VALUE: dat_r <= value.raw;
        DISP_BLANK: dat_r <= 32'(blank);
        default:    dat_r <= '0;
      endcase
    end
  end

  // Each digit decodes its own nibble unless blanked
  for (genvar i = 0; i < `NUM_DIGITS; i++) begin : g_digit
    hexdisp dec (
      .in  (value.digit[i]),
      .out (decoded[i])
    );
    assign hex[i] = blank[i] ? 7'b1111111 : decoded[i];
  end

  // Master keeps its request steady through the ack cycle
  request_held: assert property (
    @(posedge clock_50) disable iff (reset)
      access |=> (cyc && stb && $stable(adr) && $stable(we) && $stable(dat_w))
  );

endmodule

//--- logic/wb_slave_mux.sv
`timescale 1ns/1ns

module wb_slave_mux (
  input  logic        adr_sel,
  input  logic        stb,
  input  logic        enc_ack,
  input  logic        disp_ack,
  input  logic [31:0] enc_dat_r,
  input  logic [31:0] disp_dat_r,
  output logic        enc_stb,
  output logic        disp_stb,
  output logic        ack,
  output logic [31:0] dat_r
);

  // Select bit low is the encoder, high the display
  assign enc_stb  = stb & ~adr_sel;
  assign disp_stb = stb & adr_sel;

  assign ack = enc_ack | disp_ack;

  // Idle bus reads as zero
  always_comb begin
    if (enc_ack) begin
      dat_r = enc_dat_r;
    end else if (disp_ack) begin
      dat_r = disp_dat_r;
    end else begin
      dat_r = '0;
    end
  end

  // Only one slave ever holds the strobe
  acks_exclusive: assert final (!(enc_ack && disp_ack))
    else $error("both slaves acknowledged in the same cycle");

endmodule

//--- logic/encoder_soc.sv
`timescale 1ns/1ns
`include "encoder_soc_params.svh"

module encoder_soc (
  input  logic                  clock_50,
  input  logic                  reset,
  input  logic [1:0]            quad,
  input  logic                  pb,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`WB_ADDR_W-1:0] wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack,
  output logic [2:0]            rgb,
  output encoder_soc_pkg::seg_t hex0,
  output encoder_soc_pkg::seg_t hex1,
  output encoder_soc_pkg::seg_t hex2,
  output encoder_soc_pkg::seg_t hex3,
  output encoder_soc_pkg::seg_t hex4,
  output encoder_soc_pkg::seg_t hex5,
  output encoder_soc_pkg::seg_t hex6,
  output encoder_soc_pkg::seg_t hex7
);

  import encoder_soc_pkg::*;

  logic        enc_stb;
  logic        disp_stb;
  logic        enc_ack;
  logic        disp_ack;
  logic [31:0] enc_dat_r;
  logic [31:0] disp_dat_r;
  seg_t        hex [`NUM_DIGITS];

  wb_slave_mux mux0 (
    .adr_sel    (wb_adr[`WB_ADDR_W-1]),
    .stb        (wb_stb),
    .enc_ack    (enc_ack),
    .disp_ack   (disp_ack),
    .enc_dat_r  (enc_dat_r),
    .disp_dat_r (disp_dat_r),
    .enc_stb    (enc_stb),
    .disp_stb   (disp_stb),
    .ack        (wb_ack),
    .dat_r      (wb_dat_r)
  );

  // Rotary encoder with push button
  quad_encoder_wb enc0 (
    .clock_50 (clock_50),
    .reset    (reset),
    .quad     (quad),
    .button   (pb),
    .cyc      (wb_cyc),
    .stb      (enc_stb),
    .we       (wb_we),
    .adr      (wb_adr[`WB_ADDR_W-2:0]),
    .dat_w    (wb_dat_w),
    .dat_r    (enc_dat_r),
    .ack      (enc_ack),
    .rgb      (rgb)
  );

  hex_display_wb disp0 (
    .clock_50 (clock_50),
    .reset    (reset),
    .cyc      (wb_cyc),
    .stb      (disp_stb),
    .we       (wb_we),
    .adr      (wb_adr[`WB_ADDR_W-2:0]),
    .dat_w    (wb_dat_w),
    .dat_r    (disp_dat_r),
    .ack      (disp_ack),
    .hex      (hex)
  );

  // Board digit pins, hex0 is the rightmost
  assign hex0 = hex[0];
  assign hex1 = hex[1];
  assign hex2 = hex[2];
  assign hex3 = hex[3];
  assign hex4 = hex[4];
  assign hex5 = hex[5];
  assign hex6 = hex[6];
  assign hex7 = hex[7];

endmodule

//--- tb/encoder_soc_tb.sv
`timescale 1ns/1ns
`include "encoder_soc_params.svh"

module encoder_soc_tb;

  import encoder_soc_pkg::*;

  localparam int ACK_WAIT = 8;
  localparam int PIN_HOLD = 6;

  logic                   clock_50;
  logic                   reset;
  logic [1:0]             quad;
  logic                   pb;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`WB_ADDR_W-1:0]  wb_adr;
  logic [31:0]            wb_dat_w;
  logic [31:0]            wb_dat_r;
  logic                   wb_ack;
  logic [2:0]             rgb;
  seg_t                   hex_out [8];

  // One entry per pattern line
  byte                    op_q [$];
  logic [31:0]            idx_q [$];
  logic [31:0]            dat_q [$];
  logic [31:0]            exp_q [$];
  string                  name_q [$];

  // Display registers as written over the bus
  logic [31:0]            disp_value_model;
  logic [`NUM_DIGITS-1:0] disp_blank_model;

  int                     pass_count;
  int                     fail_count;
  int                     cycle_count;
  int                     cycle_limit;

  encoder_soc dut0 (
    .clock_50 (clock_50),
    .reset    (reset),
    .quad     (quad),
    .pb       (pb),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .rgb      (rgb),
    .hex0     (hex_out[0]),
    .hex1     (hex_out[1]),
    .hex2     (hex_out[2]),
    .hex3     (hex_out[3]),
    .hex4     (hex_out[4]),
    .hex5     (hex_out[5]),
    .hex6     (hex_out[6]),
    .hex7     (hex_out[7])
  );

  always #5 clock_50 = ~clock_50;

  // Lines starting with # are column notes
  task automatic load_patterns(output int count);
    int          fd;
    int          got;
    string       line;
    byte         op;
    logic [31:0] idx;
    logic [31:0] dat;
    logic [31:0] expv;
    string       name;
    count = 0;
    fd = $fopen("tb/encoder_soc_patterns.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      got = $sscanf(line, "%c %h %h %h %s", op, idx, dat, expv, name);
      if (got == 5) begin
        op_q.push_back(op);
        idx_q.push_back(idx);
        dat_q.push_back(dat);
        exp_q.push_back(expv);
        name_q.push_back(name);
      end
    end
    $fclose(fd);
    count = op_q.size();
  endtask

  // Classic cycle with the request held until ack
  task automatic bus_access(input logic write, input logic [`WB_ADDR_W-1:0] adr,
                            input logic [31:0] dat, output logic [31:0] rdat,
                            output logic acked);
    int waited;
    @(posedge clock_50);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = write;
    wb_adr   = adr;
    wb_dat_w = dat;
    waited   = 0;
    acked    = 1'b0;
    rdat     = '0;
    while (!acked && waited < ACK_WAIT) begin
      @(posedge clock_50);
      #1;
      waited++;
      if (wb_ack) begin
        acked = 1'b1;
        rdat  = wb_dat_r;
      end
    end
    // The cycle ends on the edge that samples ack
    if (acked) begin
      @(posedge clock_50);
      #1;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic hold_pins();
    repeat (PIN_HOLD) @(posedge clock_50);
    #1;
  endtask

  // B settles first and A pulses after it
  task automatic step_encoder(input int steps, input logic b);
    quad = {b, 1'b0};
    hold_pins();
    repeat (steps) begin
      quad = {b, 1'b1};
      hold_pins();
      quad = {b, 1'b0};
      hold_pins();
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actual, inout logic ok);
    assert (actual === expv) else begin
      $display("mismatch %s expected %h actual %h", name, expv, actual);
      ok = 1'b0;
    end
  endtask

  // Lit segments g to a of the usual hex glyphs, the board drives them low
  function automatic seg_t digit_pattern(input logic [3:0] nibble, input logic blanked);
    logic [6:0] lit;
    case (nibble)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'ha: lit = 7'h77;
      4'hb: lit = 7'h7C;
      4'hc: lit = 7'h39;
      4'hd: lit = 7'h5E;
      4'he: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    if (blanked) begin
      lit = 7'h00;
    end
    return ~lit;
  endfunction

  task automatic run_test(input int n);
    byte         op;
    logic [31:0] idx;
    logic [31:0] expv;
    logic [31:0] actual;
    string       name;
    logic        acked;
    logic        ok;
    op    = op_q[n];
    idx   = idx_q[n];
    expv  = exp_q[n];
    name  = name_q[n];
    ok    = 1'b1;
    acked = 1'b1;
    case (op)
      "W", "R": begin
        bus_access(op == "W", idx[`WB_ADDR_W-1:0], dat_q[n], actual, acked);
        assert (acked) else begin
          $display("%s: address %h gave no acknowledge within %0d cycles", name, idx, ACK_WAIT);
          ok = 1'b0;
        end
        if (op == "W" && acked && idx[`WB_ADDR_W-1]) begin
          case (disp_reg_e'(idx[2:0]))
            DISP_VALUE: disp_value_model = dat_q[n];
            DISP_BLANK: disp_blank_model = dat_q[n][`NUM_DIGITS-1:0];
            default:    ;
          endcase
        end
        if (op == "R" && acked) begin
          compare_value(name, expv, actual, ok);
          if (!idx[3] && enc_reg_e'(idx[2:0]) == ENC_POSITION) begin
            assert (actual < `ENC_POSITIONS) else begin
              $display("%s: position %0d is out of range", name, actual);
              ok = 1'b0;
            end
          end
        end
      end
      "Q": step_encoder(idx, dat_q[n][0]);
      "B": begin
        pb = dat_q[n][0];
        hold_pins();
      end
      "G": begin
        @(posedge clock_50);
        #1;
        compare_value(name, expv, 32'(rgb), ok);
      end
      "H": begin
        @(posedge clock_50);
        #1;
        compare_value(name, expv, 32'(hex_out[idx[2:0]]), ok);
        // Every digit against the written value and blank mask
        for (int i = 0; i < `NUM_DIGITS; i++) begin
          compare_value($sformatf("%s_hex%0d", name, i),
                        32'(digit_pattern(disp_value_model[4*i +: 4], disp_blank_model[i])),
                        32'(hex_out[i]), ok);
        end
      end
      default: begin
        $display("%s: unknown operation code %c", name, op);
        ok = 1'b0;
      end
    endcase
    if (ok) begin
      pass_count++;
      $display("%-24s ok", name);
    end else begin
      fail_count++;
      $display("%-24s FAILED", name);
    end
  endtask

  initial begin
    int line_count;
    clock_50         = 1'b0;
    reset            = 1'b1;
    quad             = 2'b00;
    pb               = 1'b0;
    wb_cyc           = 1'b0;
    wb_stb           = 1'b0;
    wb_we            = 1'b0;
    wb_adr           = '0;
    wb_dat_w         = '0;
    disp_value_model = '0;
    disp_blank_model = '0;
    pass_count       = 0;
    fail_count       = 0;
    cycle_limit      = 0;
    load_patterns(line_count);
    if (line_count == 0) begin
      $display("no patterns could be read from tb/encoder_soc_patterns.txt");
      $display("Test failed");
      $finish;
    end else begin
      cycle_limit = 20 * line_count + 100;
      repeat (2) @(posedge clock_50);
      #1;
      reset = 1'b0;
      for (int n = 0; n < line_count; n++) begin
        run_test(n);
      end
      $display("passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  // Watchdog on the total cycle count
  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clock_50);
      cycle_count++;
    end
    $display("run did not finish within %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

endmodule

//--- tb/encoder_soc_patterns.txt
# op index data expected name
# W/R bus address, Q pulses with B in data, B button level, H digit, G rgb
R 0 00000000 00000000 enc_position_reset
R 2 00000000 00000000 enc_status_reset
R 3 00000000 00000000 enc_enable_reset
R 8 00000000 00000000 disp_value_reset
R 9 00000000 00000000 disp_blank_reset
G 0 00000000 00000000 rgb_reset
H 0 00000000 00000040 hex0_reset
H 7 00000000 00000040 hex7_reset
W 0 00000016 00000000 pos_load_22
Q 5 00000000 00000000 quad_five_forward
R 0 00000000 00000003 quad_forward_wrap
W 0 00000000 00000000 pos_load_0
Q 1 00000001 00000000 quad_one_reverse
R 0 00000000 00000017 quad_reverse_wrap
W 0 0000001E 00000000 pos_load_30
R 0 00000000 00000006 pos_write_modulo
W 0 00000007 00000000 pos_load_7
R 1 00000000 00000004 color_pos7
W 3 00000001 00000000 enable_on
R 3 00000000 00000001 enable_readback
G 0 00000000 00000004 rgb_pos7
W 0 00000008 00000000 pos_load_8
R 1 00000000 00000002 color_pos8
G 0 00000000 00000002 rgb_pos8
W 0 00000010 00000000 pos_load_16
R 1 00000000 00000001 color_pos16
G 0 00000000 00000001 rgb_pos16
W 3 00000000 00000000 enable_off
G 0 00000000 00000000 rgb_disabled
B 0 00000001 00000000 button_press
R 2 00000000 00000003 status_pressed
W 2 00000000 00000000 status_clear
R 2 00000000 00000001 status_cleared_held
B 0 00000000 00000000 button_release
R 2 00000000 00000000 status_released
W 8 89ABCDEF 00000000 disp_value_write
R 8 00000000 89ABCDEF disp_value_readback
H 0 00000000 0000000E hex0_digit_f
H 7 00000000 00000000 hex7_digit_8
W 9 0000000F 00000000 disp_blank_low
H 0 00000000 0000007F hex0_blanked
H 3 00000000 0000007F hex3_blanked
H 4 00000000 00000003 hex4_digit_b
W 9 00000000 00000000 disp_blank_clear
R 0 00000000 00000010 decode_pos_kept
R 4 00000000 00000000 enc_unused_read
R F 00000000 00000000 disp_unused_read

//--- encoder_soc.f
+incdir+logic
logic/encoder_soc_pkg.sv
logic/hexdisp.sv
logic/quad_encoder_wb.sv
logic/hex_display_wb.sv
logic/wb_slave_mux.sv
logic/encoder_soc.sv
tb/encoder_soc_tb.sv

//--- Bender.yml
package:
  name: encoder_soc

sources:
  - include_dirs:
      - logic
    files:
      - logic/encoder_soc_pkg.sv
      - logic/hexdisp.sv
      - logic/quad_encoder_wb.sv
      - logic/hex_display_wb.sv
      - logic/wb_slave_mux.sv
      - logic/encoder_soc.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/encoder_soc_tb.sv
